// File: source/entropy_cfg.svh
`ifndef ENTROPY_CFG_SVH
`define ENTROPY_CFG_SVH

// signed quantized coefficient width
`define COEF_W 11

`define BLOCK_LEN 64 // coefficients per 8x8 block

// at most three ZRLs wait ahead of a nonzero AC
`define ZRL_DEPTH 4

`endif

// File: source/entropyPkg.sv
`default_nettype none

`include "entropy_cfg.svh"

package entropyPkg;

  typedef logic signed [`COEF_W-1:0] coef_t;  // two's complement
  typedef logic [`COEF_W-2:0] vli_t;
  typedef logic [3:0] size_t;
  typedef logic [3:0] run_t;
  typedef logic [5:0] index_t;  // zigzag position

  // input handshake
  typedef enum logic [1:0] {IDLE, ACK, WAIT_LOW} ctrlState_t;

  typedef enum logic {PASS, FLUSH} resolveState_t;

endpackage

`default_nettype wire

// File: source/coderControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "entropy_cfg.svh"

module coderControl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              coefReq,
  input  entropyPkg::coef_t coefData,
  input  logic              busy,
  output logic              coefAck,
  output logic              coefStb,
  output entropyPkg::coef_t coefOut,
  output logic              isFirst,
  output logic              isLast
);
  import entropyPkg::*;

  ctrlState_t state;
  index_t     index;
  logic       accept;
  logic       atLast;

  assign accept = (state == IDLE) && coefReq && !busy;  // stall while flushing
  assign atLast = (index == index_t'(`BLOCK_LEN - 1));
  assign coefAck = (state != IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      index   <= '0;
      coefStb <= 1'b0;
      isFirst <= 1'b0;
      isLast  <= 1'b0;
    end else begin
      coefStb <= accept;
      case (state)
        IDLE: begin
          if (accept) begin
            state   <= ACK;
            isFirst <= (index == '0);  // DC slot
            isLast  <= atLast;
            index   <= atLast ? '0 : index + index_t'(1);
          end
        end
        ACK:      if (!coefReq) state <= WAIT_LOW;
        WAIT_LOW: state <= IDLE;  // ack drops here
        default:  state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) coefOut <= coefData;
  end

  ackNeedsReq: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(coefAck) |-> coefReq)
    else $error("coefAck rose without coefReq");

endmodule

`default_nettype wire

// File: source/vliCoder.sv
`timescale 1ns/1ps
`default_nettype none

module vliCoder (
  input  entropyPkg::coef_t value,
  output entropyPkg::vli_t  vli,
  output entropyPkg::size_t size
);
  import entropyPkg::*;

  localparam int vliW = $bits(vli_t);

  coef_t less;
  vli_t  raw;
  vli_t  mag;

  assign less = value - coef_t'(1);

  // negatives send value-1, whose complement is the magnitude
  assign raw = (value < 0) ? less[vliW-1:0] : value[vliW-1:0];
  assign mag = (value < 0) ? ~raw : raw;

  always_comb begin
    size = '0;
    for (int i = 0; i < vliW; i++) begin
      if (mag[i]) size = size_t'(i + 1);  // highest set bit wins
    end
    for (int i = 0; i < vliW; i++) begin
      vli[i] = raw[i] & (i < int'(size));  // keep size bits
    end
  end

endmodule

`default_nettype wire

// File: source/runLengthCoder.sv
`timescale 1ns/1ps
`default_nettype none

module runLengthCoder (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              coefStb,
  input  entropyPkg::coef_t coefIn,
  input  logic              isFirst,
  input  logic              isLast,
  output logic              rawVal,
  output logic              rawDc,
  output logic              rawZrl,
  output logic              rawEnd,
  output entropyPkg::run_t  rawRun,
  output entropyPkg::size_t rawSize,
  output entropyPkg::vli_t  rawVli
);
  import entropyPkg::*;

  coef_t predDc;
  coef_t dcDiff;
  coef_t codeIn;
  run_t  runCnt;
  vli_t  vli;
  size_t size;
  logic  isZero;

  assign isZero = (coefIn == '0);
  assign dcDiff = coefIn - predDc;  // wraps modulo COEF_W
  assign codeIn = isFirst ? dcDiff : coefIn;

  vliCoder i_vliCoder (
    .value(codeIn),
    .vli  (vli),
    .size (size)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rawVal <= 1'b0;
      rawDc  <= 1'b0;
      rawZrl <= 1'b0;
      rawEnd <= 1'b0;
      predDc <= '0;
      runCnt <= '0;
    end else begin
      rawVal <= 1'b0;
      rawDc  <= 1'b0;
      rawZrl <= 1'b0;
      rawEnd <= 1'b0;
      if (coefStb) begin
        if (isFirst) begin
          rawVal <= 1'b1;
          rawDc  <= 1'b1;
          predDc <= coefIn;
          runCnt <= '0;
        end else if (!isZero) begin
          rawVal <= 1'b1;
          runCnt <= '0;
        end else if (isLast) begin
          rawVal <= 1'b1;  // block ended on zeros
          rawEnd <= 1'b1;
          runCnt <= '0;
        end else if (runCnt == '1) begin
          rawVal <= 1'b1;  // tentative ZRL
          rawZrl <= 1'b1;
          runCnt <= '0;
        end else begin
          runCnt <= runCnt + run_t'(1);
        end
      end
    end
  end

  // zero coefficients give size 0 and vli 0 for ZRL and end
  always_ff @(posedge clk) begin
    if (coefStb) begin
      rawRun  <= (isZero && isLast) ? '0 : runCnt;
      rawSize <= size;
      rawVli  <= vli;
    end
  end

  acHasBits: assert property (@(posedge clk) disable iff (!rst_n)
    coefStb && !isFirst && !isZero |=> rawVal && rawSize != '0)
    else $error("nonzero AC coded with size 0");

endmodule

`default_nettype wire

// File: source/zrlResolver.sv
`timescale 1ns/1ps
`default_nettype none

`include "entropy_cfg.svh"

module zrlResolver (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rawVal,
  input  logic              rawDc,
  input  logic              rawZrl,
  input  logic              rawEnd,
  input  entropyPkg::run_t  rawRun,
  input  entropyPkg::size_t rawSize,
  input  entropyPkg::vli_t  rawVli,
  output logic              busy,
  output logic              symVal,
  output logic              symDc,
  output logic              symEob,
  output entropyPkg::run_t  symRun,
  output entropyPkg::size_t symSize,
  output entropyPkg::vli_t  symVli
);
  import entropyPkg::*;

  localparam int cntW = $clog2(`ZRL_DEPTH + 1);

  resolveState_t   state;
  logic [cntW-1:0] zrlCnt;  // pending ZRLs, all identical
  logic            isSym;
  logic            pending;
  run_t            heldRun;
  size_t           heldSize;
  vli_t            heldVli;
  run_t            nextRun;
  size_t           nextSize;
  vli_t            nextVli;

  assign isSym   = rawVal && !rawZrl && !rawEnd;
  assign pending = (zrlCnt != '0);
  assign busy    = (state == FLUSH);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= PASS;
      zrlCnt <= '0;
      symVal <= 1'b0;
      symDc  <= 1'b0;
      symEob <= 1'b0;
    end else begin
      symVal <= 1'b0;
      symDc  <= 1'b0;
      symEob <= 1'b0;
      case (state)
        PASS: begin
          if (rawVal && rawZrl) begin
            zrlCnt <= zrlCnt + 1'b1;
          end else if (rawVal && rawEnd) begin
            zrlCnt <= '0;  // trailing ZRLs dropped
            symVal <= 1'b1;
            symEob <= 1'b1;
          end else if (isSym) begin
            symVal <= 1'b1;
            if (pending) begin
              zrlCnt <= zrlCnt - 1'b1;  // first ZRL goes now
              state  <= FLUSH;
            end else begin
              symDc <= rawDc;
            end
          end
        end
        FLUSH: begin
          symVal <= 1'b1;
          if (pending) zrlCnt <= zrlCnt - 1'b1;
          else state <= PASS;  // held symbol goes out
        end
        default: state <= PASS;
      endcase
    end
  end

  always_comb begin
    nextRun  = rawRun;
    nextSize = rawSize;
    nextVli  = rawVli;
    if (state == FLUSH && !pending) begin
      nextRun  = heldRun;
      nextSize = heldSize;
      nextVli  = heldVli;
    end else if (pending && (state == FLUSH || isSym)) begin
      nextRun  = '1;  // ZRL is run 15 size 0
      nextSize = '0;
      nextVli  = '0;
    end else if (rawEnd) begin
      nextRun  = '0;
      nextSize = '0;
      nextVli  = '0;
    end
  end

  always_ff @(posedge clk) begin
    symRun  <= nextRun;
    symSize <= nextSize;
    symVli  <= nextVli;
    if (state == PASS && isSym) begin
      heldRun  <= rawRun;
      heldSize <= rawSize;
      heldVli  <= rawVli;
    end
  end

  cntBound: assert property (@(posedge clk) disable iff (!rst_n)
    zrlCnt <= `ZRL_DEPTH)
    else $error("ZRL count overflow");

  // input stall must keep new symbols out during a flush
  noRawInFlush: assert property (@(posedge clk) disable iff (!rst_n)
    state == FLUSH |-> !rawVal)
    else $error("raw symbol arrived while flushing");

endmodule

`default_nettype wire

// File: source/entropyCoder.sv
`timescale 1ns/1ps
`default_nettype none

module entropyCoder (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              coefReq,
  input  entropyPkg::coef_t coefData,
  output logic              coefAck,
  output logic              symVal,
  output logic              symDc,
  output logic              symEob,
  output entropyPkg::run_t  symRun,
  output entropyPkg::size_t symSize,
  output entropyPkg::vli_t  symVli
);
  import entropyPkg::*;

  logic  busy, coefStb, isFirst, isLast;
  coef_t coefOut;
  logic  rawVal, rawDc, rawZrl, rawEnd;
  run_t  rawRun;
  size_t rawSize;
  vli_t  rawVli;

  coderControl i_coderControl (
    .clk, .rst_n, .coefReq, .coefData, .busy,
    .coefAck, .coefStb, .coefOut, .isFirst, .isLast
  );

  runLengthCoder i_runLengthCoder (
    .clk, .rst_n, .coefStb, .coefIn(coefOut), .isFirst, .isLast,
    .rawVal, .rawDc, .rawZrl, .rawEnd, .rawRun, .rawSize, .rawVli
  );

  zrlResolver i_zrlResolver (
    .clk, .rst_n, .rawVal, .rawDc, .rawZrl, .rawEnd, .rawRun, .rawSize, .rawVli,
    .busy, .symVal, .symDc, .symEob, .symRun, .symSize, .symVli
  );

endmodule

`default_nettype wire

// File: tests/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/entropyCoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "entropy_cfg.svh"

module entropyCoder_tb;
  import entropyPkg::*;

  typedef struct packed {
    logic  dc;
    logic  eob;
    run_t  run;
    size_t size;
    vli_t  vli;
  } symbol_t;

  logic        clk;
  logic        rst_n;
  logic        coefReq;
  coef_t       coefData;
  logic        coefAck;
  logic        symVal;
  logic        symDc;
  logic        symEob;
  run_t        symRun;
  size_t       symSize;
  vli_t        symVli;

  logic [27:0] vecMem [0:1023];
  symbol_t     gotQ [$];
  logic [15:0] lfsr;
  logic        ackPrev;
  int          ackTotal;
  int          nBlocks;
  int          errors;
  int          passCnt;
  int          failCnt;
  int          ptr;  // next record word

  clockGen i_clockGen (.clk, .rst_n);

  entropyCoder i_entropyCoder (
    .clk, .rst_n, .coefReq, .coefData, .coefAck,
    .symVal, .symDc, .symEob, .symRun, .symSize, .symVli
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic symbol_t toSymbol(input logic [27:0] w);
    return symbol_t'({w[24], w[20], w[19:16], w[15:12], w[9:0]});  // one hex digit per field
  endfunction

  task automatic nextGap(output int gap);
    gap = 0;
    for (int i = 0; i < 2; i++) begin
      lfsr = lfsrStep(lfsr);
      gap = (gap << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic sendCoef(input coef_t value);
    int gap;
    nextGap(gap);
    repeat (gap) @(posedge clk);
    coefReq  <= 1'b1;
    coefData <= value;
    do @(posedge clk); while (!coefAck);
    coefReq <= 1'b0;
    do @(posedge clk); while (coefAck);
  endtask

  task automatic reportField(input string name, input int idx, input logic [15:0] want,
                             input logic [15:0] got);
    errors++;
    $display("error %s exp %0h got %0h at symbol %0d", name, want, got, idx);
  endtask

  task automatic checkSymbol(input int idx, input symbol_t want, input symbol_t got);
    if (got.dc !== want.dc) reportField("symDc", idx, 16'(want.dc), 16'(got.dc));
    if (got.eob !== want.eob) reportField("symEob", idx, 16'(want.eob), 16'(got.eob));
    if (got.run !== want.run) reportField("symRun", idx, 16'(want.run), 16'(got.run));
    if (got.size !== want.size) reportField("symSize", idx, 16'(want.size), 16'(got.size));
    if (got.vli !== want.vli) reportField("symVli", idx, 16'(want.vli), 16'(got.vli));
  endtask

  task automatic checkCount(input string what, input int want, input int got);
    if (got < want) begin
      errors++;
      $display("missing %s: expected %0d, got %0d", what, want, got);
    end else if (got > want) begin
      errors++;
      $display("extra %s: expected %0d, got %0d", what, want, got);
    end
  endtask

  task automatic runBlock();
    logic [7:0] tag;
    int         want;
    int         errBefore;
    int         ackBefore;
    int         waited;
    tag = vecMem[ptr][7:0];
    errBefore = errors;
    ackBefore = ackTotal;
    for (int i = 1; i <= `BLOCK_LEN; i++) begin
      sendCoef(coef_t'(vecMem[ptr + i][`COEF_W-1:0]));
    end
    ptr = ptr + `BLOCK_LEN + 1;
    want = int'(vecMem[ptr]);
    waited = 0;
    do begin  // flushed ZRLs can trail the last ack
      @(negedge clk);
      waited++;
    end while (gotQ.size() < want && waited < 32);
    checkCount("symbols", want, gotQ.size());
    checkCount("coefficient acks", `BLOCK_LEN, ackTotal - ackBefore);
    for (int i = 0; i < want && i < gotQ.size(); i++) begin
      checkSymbol(i, toSymbol(vecMem[ptr + 1 + i]), gotQ[i]);
    end
    ptr = ptr + want + 1;
    gotQ.delete();
    if (errors == errBefore) begin
      passCnt++;
      $display("block %0h passed", tag);
    end else begin
      failCnt++;
      $display("block %0h failed", tag);
    end
    @(posedge clk);
  endtask

  always @(posedge clk) begin
    if (coefAck && !ackPrev) ackTotal++;  // one rise per transfer
    ackPrev = coefAck;
    if (symVal) gotQ.push_back(symbol_t'({symDc, symEob, symRun, symSize, symVli}));
  end

  initial begin
    coefReq   = 1'b0;
    coefData  = '0;
    lfsr      = 16'd25116;
    ackPrev   = 1'b0;
    ackTotal  = 0;
    errors    = 0;
    passCnt   = 0;
    failCnt   = 0;
    ptr       = 1;
    vecMem[0] = '0;
    $readmemh("tests/entropyVectors.txt", vecMem);
    nBlocks = int'(vecMem[0]);
    if (nBlocks == 0) begin
      errors++;
      $display("no test blocks found in tests/entropyVectors.txt");
    end
    @(posedge rst_n);
    @(posedge clk);
    if (coefAck !== 1'b0) begin
      errors++;
      $display("error coefAck exp 0 got %0h after reset", coefAck);
    end
    for (int b = 0; b < nBlocks; b++) begin
      runBlock();
    end
    repeat (16) @(negedge clk);
    checkCount("symbols after the last block", 0, gotQ.size());
    $display("%0d blocks passed, %0d blocks failed", passCnt, failCnt);
    if (errors == 0 && failCnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // about 12 cycles per coefficient covers gaps and flush stalls
  initial begin
    @(posedge rst_n);
    repeat ((nBlocks + 1) * `BLOCK_LEN * 12) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", (nBlocks + 1) * `BLOCK_LEN * 12);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+source
source/entropyPkg.sv
source/coderControl.sv
source/vliCoder.sv
source/runLengthCoder.sv
source/zrlResolver.sv
source/entropyCoder.sv
tests/clockGen.sv
tests/entropyCoder_tb.sv

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module entropyCoder_tb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Regression passed" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tests/entropyVectors.txt
// record: tag, 64 coefficients (11-bit hex, zigzag order, 16 per line), symbol count, symbols
// symbol: 7 hex digits giving dc, eob, run, size, then 3 digits of vli
07
01 005 003 000 7fe 000 000 001 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
05 1003005 0002003 0012001 0021001 0100000
02 7f9 7ff 064 79c 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
05 1004003 0001000 0007064 000701b 0100000
03 7f9 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 001 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 7fd 000 000 000 000 000 000 000 000 000 000 000 000
07 1000000 00f0000 0001001 00f0000 00f0000 0012000 0100000
04 00a 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 3ff
05 1005011 00f0000 00f0000 00f0000 00ea3ff
05 00a 600 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
03 1000000 000a1ff 0100000
06 418 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
02 100a00d 0100000
07 418 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
007 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 7ff 002
06 1000000 00f3007 00f0000 00f0000 00d1000 0002002
